//--- flist.f
+incdir+.
pll_pkg.sv
pll_cfg_producer.sv
pll_cfg_fifo.sv
pll_core.sv
pll_subsys.sv
pll_assertions.sv
tb_pll_subsys.sv

//--- pll_assertions.sv
// PLL subsystem protocol checks
// credit, FIFO and lock rules, bound into the subsystem top

`timescale 1ns/1ns
`default_nettype none

`include "pll_config.svh"

module pll_assertions (
   input wire                      en,
   input wire                      en_n,
   input wire                      push,
   input wire                      pop,
   input wire                      empty,
   input wire                      freqlock,
   input wire pll_pkg::credit_t    credits,   // producer counter
   input wire pll_pkg::pll_state_t state      // core FSM
);

   import pll_pkg::*;

   // push follows an accept, which needs a credit
   a_push_credit: assert property (@(posedge en) disable iff (!en_n)
      push |-> $past(credits != '0))
      else $error("push issued without a credit");

   a_pop_empty: assert property (@(posedge en) disable iff (!en_n)
      pop |-> !empty)
      else $error("pop on an empty FIFO");

   a_credit_max: assert property (@(posedge en) disable iff (!en_n)
      credits <= credit_t'(`PLL_FIFO_DEPTH))
      else $error("credit count above FIFO depth");

   a_off_unlocked: assert property (@(posedge en) disable iff (!en_n)
      (state == PLL_OFF) |-> !freqlock)
      else $error("freqlock high while core is off");

endmodule

bind pll_subsys pll_assertions i_pll_assertions (
   .en(en), .en_n(en_n), .push(push), .pop(pop), .empty(empty), .freqlock(freqlock),
   .credits(i_producer.credits), .state(i_core.state)
);

`default_nettype wire

//--- pll_cfg_fifo.sv
// PLL configuration FIFO
// circular buffer of configuration words with a fall-through head
// every pop is returned to the producer as a registered credit

`timescale 1ns/1ns
`default_nettype none

`include "pll_config.svh"

module pll_cfg_fifo (
   input  wire                     en,
   input  wire                     en_n,
   input  wire                     push,          // write head of tail
   input  wire pll_pkg::divin_t    push_divin,
   input  wire pll_pkg::divfb_t    push_divfb,
   input  wire pll_pkg::divfrac_t  push_divfrac,
   input  wire pll_pkg::divout_t   push_divout,
   input  wire                     push_clken,
   input  wire                     pop,           // consume head
   output logic                    empty,
   output pll_pkg::divin_t         head_divin,
   output pll_pkg::divfb_t         head_divfb,
   output pll_pkg::divfrac_t       head_divfrac,
   output pll_pkg::divout_t        head_divout,
   output logic                    head_clken,
   output logic                    credit_ret     // cycle after pop
);

   import pll_pkg::*;

   localparam int DEPTH = `PLL_FIFO_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   divin_t     mem_divin   [DEPTH];
   divfb_t     mem_divfb   [DEPTH];
   divfrac_t   mem_divfrac [DEPTH];
   divout_t    mem_divout  [DEPTH];
   logic       mem_clken   [DEPTH];
   logic [PTR_W-1:0] wr_ptr;  // next free slot
   logic [PTR_W-1:0] rd_ptr;  // current head
   logic [CNT_W-1:0] count;   // occupancy
   logic             do_pop;

   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;  // wrap at depth
   endfunction

   assign empty  = (count == '0);
   assign do_pop = pop & ~empty;  // ignore pop on empty

   // fall-through head
   assign head_divin   = mem_divin[rd_ptr];
   assign head_divfb   = mem_divfb[rd_ptr];
   assign head_divfrac = mem_divfrac[rd_ptr];
   assign head_divout  = mem_divout[rd_ptr];
   assign head_clken   = mem_clken[rd_ptr];

   //##############################
   // pointers and occupancy
   //##############################
   always_ff @(posedge en or negedge en_n) begin
      if (!en_n) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         credit_ret <= 1'b0;
      end else begin
         credit_ret <= do_pop;  // slot freed, tell producer
         if (push) wr_ptr <= ptr_next(wr_ptr);
         if (do_pop) rd_ptr <= ptr_next(rd_ptr);
         case ({push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // storage
   always_ff @(posedge en) begin
      if (push) begin
         mem_divin[wr_ptr]   <= push_divin;
         mem_divfb[wr_ptr]   <= push_divfb;
         mem_divfrac[wr_ptr] <= push_divfrac;
         mem_divout[wr_ptr]  <= push_divout;
         mem_clken[wr_ptr]   <= push_clken;
      end
   end

endmodule

`default_nettype wire

//--- pll_cfg_producer.sv
// PLL configuration producer
// takes host words while it holds a credit and forwards them to the
// config FIFO one cycle later; one credit comes back per FIFO pop

`timescale 1ns/1ns
`default_nettype none

`include "pll_config.svh"

module pll_cfg_producer (
   input  wire                     en,           // reference clock
   input  wire                     en_n,         // async reset, active low
   input  wire                     cfg_valid,    // host word present
   input  wire pll_pkg::divin_t    cfg_divin,
   input  wire pll_pkg::divfb_t    cfg_divfb,
   input  wire pll_pkg::divfrac_t  cfg_divfrac,
   input  wire pll_pkg::divout_t   cfg_divout,
   input  wire                     cfg_clken,
   input  wire                     credit_ret,   // one slot freed
   output logic                    cfg_ready,    // credit available
   output logic                    push,         // write strobe to FIFO
   output pll_pkg::divin_t         push_divin,
   output pll_pkg::divfb_t         push_divfb,
   output pll_pkg::divfrac_t       push_divfrac,
   output pll_pkg::divout_t        push_divout,
   output logic                    push_clken
);

   import pll_pkg::*;

   credit_t credits;  // free FIFO slots as seen here
   logic    accept;   // host handshake this cycle

   assign cfg_ready = (credits != '0);
   assign accept    = cfg_valid & cfg_ready;

   //##############################
   // credit counter
   //##############################
   always_ff @(posedge en or negedge en_n) begin
      if (!en_n) begin
         credits <= credit_t'(`PLL_FIFO_DEPTH);  // FIFO starts empty
         push    <= 1'b0;
      end else begin
         push <= accept;  // word goes out next cycle
         case ({accept, credit_ret})
            2'b10:   credits <= credits - 1'b1;  // spent on accept
            2'b01:   credits <= credits + 1'b1;  // returned by pop
            default: credits <= credits;         // none, or both cancel
         endcase
      end
   end

   // output stage, valid only with push
   always_ff @(posedge en) begin
      if (accept) begin
         push_divin   <= cfg_divin;
         push_divfb   <= cfg_divfb;
         push_divfrac <= cfg_divfrac;
         push_divout  <= cfg_divout;
         push_clken   <= cfg_clken;
      end
   end

endmodule

`default_nettype wire

//--- pll_config.svh
// PLL subsystem sizing
// widths of the divider fields, FIFO depth, credit counter and lock time
// shared by the package and every module of the subsystem

`ifndef PLL_CONFIG_SVH
`define PLL_CONFIG_SVH

//##############################
// divider fields
//##############################
`define PLL_DIVIN_W    8   // reference divider M
`define PLL_DIVFB_W    8   // integer part of N
`define PLL_FRAC_W     8   // fraction of N, 1/256 steps
`define PLL_DIVOUT_W   8   // post divider

//##############################
// flow control and lock
//##############################
`define PLL_FIFO_DEPTH 4   // config words in flight
`define PLL_CREDIT_W   3   // holds 0..depth
`define PLL_LOCK_TIME  32  // fb ticks to freqlock
`define PLL_ACC_W      17  // divin*256 plus one step

`endif

//--- pll_core.sv
// PLL core, cycle based
// fractional-N phase accumulator gives the vco tick, divider N the
// feedback tick, the post divider the output strobe; a lock counter on
// feedback ticks raises freqlock, bypass forces the output strobe

`timescale 1ns/1ns
`default_nettype none

`include "pll_config.svh"

module pll_core (
   input  wire                     en,
   input  wire                     en_n,
   input  wire                     empty,         // no config waiting
   input  wire pll_pkg::divin_t    head_divin,
   input  wire pll_pkg::divfb_t    head_divfb,
   input  wire pll_pkg::divfrac_t  head_divfrac,
   input  wire pll_pkg::divout_t   head_divout,
   input  wire                     head_clken,
   input  wire                     bypass,
   output logic                    pop,           // take head word
   output logic                    vco_tick,
   output logic                    fb_tick,
   output logic                    out_strobe,
   output logic                    freqlock,
   output logic                    bypass_active
);

   import pll_pkg::*;

   localparam int LOCK_W = $clog2(`PLL_LOCK_TIME + 1);

   pll_state_t        state;
   divin_t            divin_r;     // active config
   divfb_t            divfb_r;
   divfrac_t          divfrac_r;
   divout_t           divout_r;
   logic              clken_r;
   acc_t              acc;         // vco phase, always below M
   acc_t              acc_sum;
   acc_t              step;        // N in 1/256 units
   acc_t              modulus;     // M in 1/256 units
   acc_t              head_step;
   acc_t              head_mod;
   divfb_t            fb_cnt;      // vco ticks since last fb tick
   divout_t           out_cnt;     // vco ticks since last strobe
   logic [LOCK_W-1:0] lock_cnt;    // fb ticks while acquiring
   logic              head_ok;     // waiting ratio usable
   logic              running;
   logic              locked;
   logic              fb_wrap;
   logic              out_wrap;

   //##############################
   // ratio decode
   //##############################
   assign step      = acc_t'({divfb_r, divfrac_r});
   assign modulus   = acc_t'({divin_r, {`PLL_FRAC_W{1'b0}}});
   assign head_step = acc_t'({head_divfb, head_divfrac});
   assign head_mod  = acc_t'({head_divin, {`PLL_FRAC_W{1'b0}}});
   assign head_ok   = (head_divin != '0) && (head_step != '0) && (head_step < head_mod);

   assign pop     = ~empty;  // new word overrides at once
   assign running = (state != PLL_OFF);
   assign locked  = (state == PLL_LOCKED);

   //##############################
   // tick generation
   //##############################
   assign acc_sum  = acc + step;
   assign vco_tick = running && (acc_sum >= modulus);  // phase wraps past M
   assign fb_wrap  = (divfb_r <= divfb_t'(1)) || (fb_cnt == divfb_r - 1'b1);
   assign out_wrap = (divout_r <= divout_t'(1)) || (out_cnt == divout_r - 1'b1);
   assign fb_tick  = vco_tick && fb_wrap;

   assign out_strobe    = bypass | (locked & clken_r & vco_tick & out_wrap);
   assign freqlock      = locked;
   assign bypass_active = bypass;

   //##############################
   // FSM and counters
   //##############################
   always_ff @(posedge en or negedge en_n) begin
      if (!en_n) begin
         state    <= PLL_OFF;
         acc      <= '0;
         fb_cnt   <= '0;
         out_cnt  <= '0;
         lock_cnt <= '0;
      end else if (pop) begin
         state    <= head_ok ? PLL_ACQUIRE : PLL_OFF;  // bad ratio parks
         acc      <= '0;  // restart phase
         fb_cnt   <= '0;
         out_cnt  <= '0;
         lock_cnt <= '0;  // relock from scratch
      end else if (running) begin
         acc <= vco_tick ? acc_sum - modulus : acc_sum;
         if (vco_tick) fb_cnt <= fb_wrap ? '0 : fb_cnt + 1'b1;
         if (locked && vco_tick) out_cnt <= out_wrap ? '0 : out_cnt + 1'b1;
         if (state == PLL_ACQUIRE && fb_tick) begin
            if (lock_cnt == LOCK_W'(`PLL_LOCK_TIME - 1)) state <= PLL_LOCKED;
            lock_cnt <= lock_cnt + 1'b1;
         end
      end
   end

   // config capture on pop
   always_ff @(posedge en) begin
      if (pop) begin
         divin_r   <= head_divin;
         divfb_r   <= head_divfb;
         divfrac_r <= head_divfrac;
         divout_r  <= head_divout;
         clken_r   <= head_clken;
      end
   end

endmodule

`default_nettype wire

//--- pll_pkg.sv
// PLL subsystem types
// vector typedefs for the configuration fields, the credit count and
// the phase accumulator, plus the core state encoding

`default_nettype none

`include "pll_config.svh"

package pll_pkg;

   //##############################
   // configuration fields
   //##############################
   typedef logic [`PLL_DIVIN_W-1:0]  divin_t;    // reference divider M
   typedef logic [`PLL_DIVFB_W-1:0]  divfb_t;    // integer N
   typedef logic [`PLL_FRAC_W-1:0]   divfrac_t;  // fractional N
   typedef logic [`PLL_DIVOUT_W-1:0] divout_t;   // post divider

   //##############################
   // internal counters
   //##############################
   typedef logic [`PLL_CREDIT_W-1:0] credit_t;   // producer credits
   typedef logic [`PLL_ACC_W-1:0]    acc_t;      // vco phase

   // core FSM
   typedef enum logic [1:0] {
      PLL_OFF     = 2'd0,  // idle or bad ratio
      PLL_ACQUIRE = 2'd1,  // counting fb ticks
      PLL_LOCKED  = 2'd2   // freqlock up
   } pll_state_t;

endpackage

`default_nettype wire

//--- pll_subsys.sv
// PLL subsystem top
// host config path through the credit producer and config FIFO into
// the PLL core, all clocked by the reference clock

`timescale 1ns/1ns
`default_nettype none

module pll_subsys (
   input  wire                     en,
   input  wire                     en_n,
   input  wire                     cfg_valid,
   input  wire pll_pkg::divin_t    cfg_divin,
   input  wire pll_pkg::divfb_t    cfg_divfb,
   input  wire pll_pkg::divfrac_t  cfg_divfrac,
   input  wire pll_pkg::divout_t   cfg_divout,
   input  wire                     cfg_clken,
   input  wire                     bypass,
   output logic                    cfg_ready,
   output logic                    vco_tick,
   output logic                    fb_tick,
   output logic                    out_strobe,
   output logic                    freqlock,
   output logic                    bypass_active
);

   import pll_pkg::*;

   // producer to FIFO
   logic     push;
   divin_t   push_divin;
   divfb_t   push_divfb;
   divfrac_t push_divfrac;
   divout_t  push_divout;
   logic     push_clken;
   logic     credit_ret;
   // FIFO to core
   logic     empty;
   logic     pop;
   divin_t   head_divin;
   divfb_t   head_divfb;
   divfrac_t head_divfrac;
   divout_t  head_divout;
   logic     head_clken;

   pll_cfg_producer i_producer (
      .en, .en_n, .cfg_valid, .cfg_divin, .cfg_divfb, .cfg_divfrac, .cfg_divout,
      .cfg_clken, .credit_ret, .cfg_ready, .push, .push_divin, .push_divfb,
      .push_divfrac, .push_divout, .push_clken
   );

   pll_cfg_fifo i_fifo (
      .en, .en_n, .push, .push_divin, .push_divfb, .push_divfrac, .push_divout,
      .push_clken, .pop, .empty, .head_divin, .head_divfb, .head_divfrac,
      .head_divout, .head_clken, .credit_ret
   );

   pll_core i_core (
      .en, .en_n, .empty, .head_divin, .head_divfb, .head_divfrac, .head_divout,
      .head_clken, .bypass, .pop, .vco_tick, .fb_tick, .out_strobe, .freqlock,
      .bypass_active
   );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the PLL subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f flist.f \
   --top-module tb_pll_subsys -o tb_sim

out=$(./obj_dir/tb_sim)
printf '%s\n' "$out"

# pass only if the testbench printed its pass line
printf '%s\n' "$out" | grep -qx "Test OK"

//--- tb_pll_subsys.sv
// PLL subsystem testbench
// directed tests of reset, lock, output divider, bad ratios, credit
// flow and bypass, with cycle counts checked against the ratio rules

`timescale 1ns/1ns
`default_nettype none

`include "pll_config.svh"

module tb_pll_subsys;

   import pll_pkg::*;

   localparam int CLK_NS    = 40;
   localparam int NUM_TESTS = 6;

   logic     en, en_n, cfg_valid, cfg_clken, bypass;
   divin_t   cfg_divin;
   divfb_t   cfg_divfb;
   divfrac_t cfg_divfrac;
   divout_t  cfg_divout;
   logic     cfg_ready, vco_tick, fb_tick, out_strobe, freqlock, bypass_active;

   int errors = 0;
   int checks = 0;
   int seed = 32'h52f2;
   int n_vco, n_fb, n_out, n_lock, n_byp;  // window counts
   int n_stall;                            // cycles host saw no ready
   int pop_total = 0;                      // words taken by the core

   pll_subsys i_pll_subsys (
      .en, .en_n, .cfg_valid, .cfg_divin, .cfg_divfb, .cfg_divfrac, .cfg_divout,
      .cfg_clken, .bypass, .cfg_ready, .vco_tick, .fb_tick, .out_strobe, .freqlock,
      .bypass_active
   );

   initial begin
      en = 1'b0;
      forever #(CLK_NS / 2) en = ~en;
   end

   always @(negedge en) if (i_pll_subsys.pop) pop_total++;

   //##############################
   // compare tasks
   //##############################
   task automatic check_count(input string name, input int exp, input int act);
      checks++;
      if (exp != act) begin
         $display("ERROR %0t %s expected %0d actual %0d", $time, name, exp, act);
         errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      checks++;
      if (exp !== act) begin
         $display("ERROR %0t %s expected %b actual %b", $time, name, exp, act);
         errors++;
      end
   endtask

   task automatic check_divout(input string name, input divout_t exp, input divout_t act);
      checks++;
      if (exp !== act) begin
         $display("ERROR %0t %s expected %0d actual %0d", $time, name, exp, act);
         errors++;
      end
   endtask

   task automatic check_near(input string name, input int exp, input int act);
      if (act < exp - 1 || act > exp + 1) check_count(name, exp, act);  // window edge slack
      else checks++;
   endtask

   //##############################
   // drive and sample helpers
   //##############################
   task automatic step_cycle;
      @(posedge en);
      #2;  // drive point
   endtask

   task automatic send_word(input divin_t di, input divfb_t fb, input divfrac_t fr,
                            input divout_t dout, input logic ck);
      cfg_valid   = 1'b1;
      cfg_divin   = di;
      cfg_divfb   = fb;
      cfg_divfrac = fr;
      cfg_divout  = dout;
      cfg_clken   = ck;
      @(negedge en);
      while (!cfg_ready) begin  // host waits for credit
         n_stall++;
         @(negedge en);
      end
      step_cycle;  // transfer took place at this edge
      cfg_valid = 1'b0;
   endtask

   // word is loaded two cycles after transfer and runs from the next one
   task automatic load_cfg(input divin_t di, input divfb_t fb, input divfrac_t fr,
                           input divout_t dout, input logic ck);
      send_word(di, fb, fr, dout, ck);
      repeat (2) @(posedge en);
      #2;
   endtask

   task automatic sample_cycles(input int cycles);
      n_vco = 0;
      n_fb = 0;
      n_out = 0;
      n_lock = 0;
      n_byp = 0;
      repeat (cycles) begin
         @(negedge en);  // outputs settled mid cycle
         n_vco  += int'(vco_tick);
         n_fb   += int'(fb_tick);
         n_out  += int'(out_strobe);
         n_lock += int'(freqlock);
         n_byp  += int'(bypass_active);
      end
      step_cycle;
   endtask

   task automatic wait_lock;
      int cyc;
      cyc = 0;
      @(negedge en);
      while (!freqlock && cyc < 4000) begin
         cyc++;
         @(negedge en);
      end
      if (!freqlock) begin
         $display("freqlock did not rise within 4000 cycles at %0t", $time);
         errors++;
      end
      step_cycle;
   endtask

   // vco ticks from one out_strobe to the next
   task automatic measure_divout(output divout_t d);
      int cnt, cyc;
      cnt = 0;
      cyc = 0;
      @(negedge en);
      while (!out_strobe && cyc < 2000) begin
         cyc++;
         @(negedge en);
      end
      @(negedge en);
      while (!out_strobe && cyc < 4000) begin
         cyc++;
         cnt += int'(vco_tick);
         @(negedge en);
      end
      d = divout_t'(cnt + 1);  // closing strobe sits on a tick
      step_cycle;
   endtask

   function automatic int vco_expect(input int w, input int di, input int fb, input int fr);
      return (w * (fb * 256 + fr)) / (di * 256);  // floor(W*step/M)
   endfunction

   task automatic finish_test(input string name, input int e0);
      $display("test %-10s %s (%0d errors)", name, (errors == e0) ? "pass" : "fail",
               errors - e0);
   endtask

   //##############################
   // tests
   //##############################
   task automatic test_reset;
      int e0;
      e0 = errors;
      @(negedge en);
      check_flag("cfg_ready", 1'b1, cfg_ready);
      check_flag("vco_tick", 1'b0, vco_tick);
      check_flag("fb_tick", 1'b0, fb_tick);
      check_flag("out_strobe", 1'b0, out_strobe);
      check_flag("freqlock", 1'b0, freqlock);
      check_flag("bypass_active", 1'b0, bypass_active);
      step_cycle;
      load_cfg(8'd4, 8'd1, 8'd0, 8'd1, 1'b1);
      sample_cycles(100);
      check_count("vco_tick count", vco_expect(100, 4, 1, 0), n_vco);
      finish_test("reset", e0);
   endtask

   task automatic test_lock;
      int e0, k, r, n_v, n_f, cyc;
      divin_t di;
      divfb_t fb;
      divfrac_t fr;
      logic exp_fb;
      e0 = errors;
      for (k = 0; k < 3; k++) begin
         r = $random(seed);
         fb = divfb_t'(1 + ($unsigned(r) % 3));
         r = $random(seed);
         di = divin_t'(int'(fb) + 1 + ($unsigned(r) % 4));  // keeps step below M
         fr = divfrac_t'($random(seed));
         load_cfg(di, fb, fr, 8'd1, 1'b1);
         n_v = 0;
         n_f = 0;
         cyc = 0;
         while (n_f < `PLL_LOCK_TIME && cyc < 4000) begin
            @(negedge en);
            cyc++;
            check_flag("freqlock", 1'b0, freqlock);
            if (vco_tick) n_v++;
            exp_fb = vco_tick && (fb <= 1 || n_v % int'(fb) == 0);
            check_flag("fb_tick", exp_fb, fb_tick);
            if (exp_fb) n_f++;
         end
         @(negedge en);
         check_flag("freqlock", 1'b1, freqlock);  // cycle after last fb tick
         step_cycle;
      end
      finish_test("lock", e0);
   endtask

   task automatic test_out_div;
      int e0;
      divout_t d;
      e0 = errors;
      load_cfg(8'd4, 8'd2, 8'd64, 8'd3, 1'b1);
      wait_lock;
      sample_cycles(300);
      check_near("out_strobe count", n_vco / 3, n_out);
      measure_divout(d);
      check_divout("out divider", 8'd3, d);
      load_cfg(8'd4, 8'd2, 8'd64, 8'd3, 1'b0);  // gate closed
      wait_lock;
      sample_cycles(200);
      check_count("out_strobe count", 0, n_out);
      load_cfg(8'd4, 8'd2, 8'd64, 8'd0, 1'b1);  // divout 0 passes every tick
      wait_lock;
      sample_cycles(200);
      check_count("out_strobe count", n_vco, n_out);
      finish_test("out_div", e0);
   endtask

   task automatic expect_idle;
      sample_cycles(200);
      check_count("vco_tick count", 0, n_vco);
      check_count("freqlock cycles", 0, n_lock);
   endtask

   task automatic test_invalid;
      int e0;
      e0 = errors;
      load_cfg(8'd4, 8'd0, 8'd0, 8'd1, 1'b1);   // step 0
      expect_idle;
      load_cfg(8'd2, 8'd2, 8'd0, 8'd1, 1'b1);   // step equals M
      expect_idle;
      load_cfg(8'd3, 8'd5, 8'd10, 8'd1, 1'b1);  // step above M
      expect_idle;
      load_cfg(8'd0, 8'd1, 8'd0, 8'd1, 1'b1);   // divin 0
      expect_idle;
      load_cfg(8'd5, 8'd2, 8'd0, 8'd1, 1'b1);   // recovery
      sample_cycles(200);
      check_count("vco_tick count", vco_expect(200, 5, 2, 0), n_vco);
      wait_lock;
      finish_test("invalid", e0);
   endtask

   task automatic test_credits;
      int e0, i, pops0;
      divout_t d;
      e0 = errors;
      n_stall = 0;
      pops0 = pop_total;
      for (i = 0; i < 5; i++) begin  // valid stays high across words
         send_word(divin_t'(4 + i), divfb_t'(1 + i), divfrac_t'(32 * i),
                   divout_t'(1 + i), 1'b1);
      end
      repeat (2) @(posedge en);
      #2;
      // each credit returns three cycles after its transfer so four never run out
      check_count("cfg_ready low cycles", 0, n_stall);
      check_count("words popped", 5, pop_total - pops0);
      sample_cycles(256);
      check_count("vco_tick count", vco_expect(256, 8, 5, 128), n_vco);
      check_count("fb_tick count", vco_expect(256, 8, 5, 128) / 5, n_fb);  // every fifth tick
      wait_lock;
      measure_divout(d);
      check_divout("out divider", 8'd5, d);
      finish_test("credits", e0);
   endtask

   task automatic test_bypass;
      int e0;
      e0 = errors;
      bypass = 1'b1;  // core locked here
      sample_cycles(50);
      check_count("out_strobe cycles", 50, n_out);
      check_count("bypass_active cycles", 50, n_byp);
      load_cfg(8'd0, 8'd1, 8'd0, 8'd1, 1'b1);  // core parked off
      sample_cycles(50);
      check_count("out_strobe cycles", 50, n_out);
      check_count("bypass_active cycles", 50, n_byp);
      check_count("freqlock cycles", 0, n_lock);
      bypass = 1'b0;
      sample_cycles(20);
      check_count("out_strobe cycles", 0, n_out);
      check_count("bypass_active cycles", 0, n_byp);
      finish_test("bypass", e0);
   endtask

   //##############################
   // run control
   //##############################
   initial begin
      #(NUM_TESTS * 4000 * CLK_NS);
      $display("watchdog expired, tests did not finish in time");
      $display("Test FAILED");
      $finish;
   end

   initial begin
      en_n        = 1'b0;
      cfg_valid   = 1'b0;
      cfg_divin   = '0;
      cfg_divfb   = '0;
      cfg_divfrac = '0;
      cfg_divout  = '0;
      cfg_clken   = 1'b0;
      bypass      = 1'b0;
      n_stall     = 0;
      repeat (3) @(posedge en);
      #2;
      en_n = 1'b1;
      test_reset;
      test_lock;
      test_out_div;
      test_invalid;
      test_credits;
      test_bypass;
      $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
